// File: project.f
design/axi4s_pkg.sv
design/axi4s_intf.sv
design/axi4s_shift.sv
design/axi4s_dispatch.sv
design/axi4s_collect.sv
design/axi4s_rotator_top.sv
test/axi4s_rotator_asserts.sv
test/tb_axi4s_rotator.sv

// File: Makefile
# Verilator build and run for the axi4s packet byte rotator

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi4s_rotator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a simulator error exit counts as a failed run
test: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || echo "=== FAIL ===" >> $(LOG)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_axi4s_rotator.sv
/*
 * testbench for the axi4s packet byte rotator
 * table-driven packets against a reference rotate model,
 * with back-pressure, per-packet shift and latency checks
 */

`timescale 1ns/1ps

module tb_axi4s_rotator;

   // one table row is one packet
   typedef struct {
      string              name;
      int                 len;
      axi4s_pkg::shift_t  shift;
      axi4s_pkg::tkeep_t  keep;
      bit                 bp;
   } entry_t;

   logic               aclk;
   logic               rst_n;
   logic               in_tvalid;
   logic               in_tready;
   axi4s_pkg::tdata_t  in_tdata;
   axi4s_pkg::tkeep_t  in_tkeep;
   logic               in_tlast;
   axi4s_pkg::shift_t  shift;
   logic               out_tvalid;
   logic               out_tready;
   axi4s_pkg::tdata_t  out_tdata;
   axi4s_pkg::tkeep_t  out_tkeep;
   logic               out_tlast;

   entry_t             tbl [$];
   // expected beats, in input order
   axi4s_pkg::tdata_t  exp_data [$];
   axi4s_pkg::tkeep_t  exp_keep [$];
   logic               exp_last [$];
   int                 exp_cyc  [$];
   int                 exp_test [$];

   logic               bp_on;
   logic [31:0]        rnd;
   int                 in_test;
   int                 cycle;
   int                 idx;
   int                 wd_cycles;
   logic               in_first;
   axi4s_pkg::shift_t  pkt_shift;
   int                 err_data;
   int                 err_keep;
   int                 err_last;
   int                 err_other;

   axi4s_rotator_top UUT (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .in_tvalid  (in_tvalid),
      .in_tready  (in_tready),
      .in_tdata   (in_tdata),
      .in_tkeep   (in_tkeep),
      .in_tlast   (in_tlast),
      .shift      (shift),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast)
   );

   // 40 ns period
   always #20 aclk = ~aclk;

   // --------------------
   // reference model
   // --------------------

   // byte b lands at b+s, top bytes wrap to the bottom
   function automatic axi4s_pkg::tdata_t rotate_data(axi4s_pkg::tdata_t d,
                                                     axi4s_pkg::shift_t s);
      axi4s_pkg::tdata_t r;
      for (int b = 0; b < axi4s_pkg::DATA_BYTES; b++) begin
         r[(b + int'(s)) % axi4s_pkg::DATA_BYTES] = d[b];
      end
      return r;
   endfunction

   function automatic axi4s_pkg::tkeep_t rotate_keep(axi4s_pkg::tkeep_t k,
                                                     axi4s_pkg::shift_t s);
      axi4s_pkg::tkeep_t r;
      for (int b = 0; b < axi4s_pkg::DATA_BYTES; b++) begin
         r[(b + int'(s)) % axi4s_pkg::DATA_BYTES] = k[b];
      end
      return r;
   endfunction

   // --------------------
   // compare tasks
   // --------------------

   task automatic check_data(string name, axi4s_pkg::tdata_t exp, axi4s_pkg::tdata_t act);
      if (act !== exp) begin
         $display("FAILED %s: tdata expected %h actual %h", name, exp, act);
         err_data++;
      end
   endtask

   task automatic check_keep(string name, axi4s_pkg::tkeep_t exp, axi4s_pkg::tkeep_t act);
      if (act !== exp) begin
         $display("FAILED %s: tkeep expected %h actual %h", name, exp, act);
         err_keep++;
      end
   endtask

   task automatic check_last(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("FAILED %s: tlast expected %b actual %b", name, exp, act);
         err_last++;
      end
   endtask

   task automatic check_valid(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("FAILED %s: out_tvalid expected %b actual %b", name, exp, act);
         err_other++;
      end
   endtask

   task automatic check_latency(string name, int exp, int act);
      if (act != exp) begin
         $display("FAILED %s: latency expected %0d actual %0d", name, exp, act);
         err_other++;
      end
   endtask

   task automatic report_counts();
      $display("errors: data %0d keep %0d last %0d other %0d total %0d",
               err_data, err_keep, err_last, err_other,
               err_data + err_keep + err_last + err_other);
   endtask

   // --------------------
   // packet table
   // --------------------

   task automatic add_entry(string name, int len, axi4s_pkg::shift_t sh,
                            axi4s_pkg::tkeep_t keep, bit bp);
      entry_t e;
      e.name  = name;
      e.len   = len;
      e.shift = sh;
      e.keep  = keep;
      e.bp    = bp;
      tbl.push_back(e);
   endtask

   task automatic build_table();
      // every shift once, partial final keep on most
      add_entry("pass_thru", 3, 3'd0, 8'hFF, 1'b0);
      add_entry("rot_1",     2, 3'd1, 8'h0F, 1'b0);
      add_entry("rot_2",     4, 3'd2, 8'h07, 1'b0);
      add_entry("rot_3",     1, 3'd3, 8'hFF, 1'b0);
      add_entry("rot_4",     3, 3'd4, 8'h01, 1'b0);
      add_entry("rot_5",     2, 3'd5, 8'h3F, 1'b0);
      add_entry("rot_6",     5, 3'd6, 8'h1F, 1'b0);
      add_entry("rot_7",     2, 3'd7, 8'h7F, 1'b0);
      // more packets than lanes under random out_tready
      add_entry("bp_pkt_a",  3, 3'd2, 8'h03, 1'b1);
      add_entry("bp_pkt_b",  1, 3'd5, 8'hFF, 1'b1);
      add_entry("bp_pkt_c",  6, 3'd7, 8'h3F, 1'b1);
      add_entry("bp_pkt_d",  4, 3'd1, 8'h0F, 1'b1);
      add_entry("bp_pkt_e",  2, 3'd6, 8'hFF, 1'b1);
      add_entry("bp_pkt_f",  5, 3'd3, 8'h07, 1'b1);
      add_entry("after_bp",  3, 3'd4, 8'hFF, 1'b0);
   endtask

   // --------------------
   // driver
   // --------------------

   // later beats get a different shift, only the first one counts
   task automatic send_packet(int t);
      for (int b = 0; b < tbl[t].len; b++) begin
         in_tvalid <= 1'b1;
         in_tdata  <= {$urandom, $urandom};
         in_tkeep  <= (b == tbl[t].len - 1) ? tbl[t].keep : '1;
         in_tlast  <= (b == tbl[t].len - 1);
         in_test   <= t;
         if (b == 0) begin
            shift <= tbl[t].shift;
         end else begin
            shift <= axi4s_pkg::shift_t'(int'(tbl[t].shift) + 1 + int'($urandom % 7));
         end
         @(posedge aclk);
         while (!in_tready) begin
            @(posedge aclk);
         end
      end
      in_tvalid <= 1'b0;
      in_tlast  <= 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_data.size() != 0) begin
         @(posedge aclk);
      end
   endtask

   // random sink ready while back-pressure is on
   always @(posedge aclk) begin
      if (bp_on) begin
         rnd = $urandom;
         out_tready <= rnd[0];
      end else begin
         out_tready <= 1'b1;
      end
   end

   // --------------------
   // monitor
   // --------------------

   always @(posedge aclk) begin
      cycle++;
      if (rst_n) begin
         if (in_tvalid && in_tready) begin
            // shift sampled on the first beat only
            if (in_first) begin
               pkt_shift = shift;
            end
            exp_data.push_back(rotate_data(in_tdata, pkt_shift));
            exp_keep.push_back(rotate_keep(in_tkeep, pkt_shift));
            exp_last.push_back(in_tlast);
            exp_cyc.push_back(cycle);
            exp_test.push_back(in_test);
            in_first = in_tlast;
         end
         if (out_tvalid && out_tready) begin
            if (exp_data.size() == 0) begin
               $display("ERROR: output beat arrived with no matching input beat");
               err_other++;
            end else begin
               idx = exp_test.pop_front();
               check_data(tbl[idx].name, exp_data.pop_front(), out_tdata);
               check_keep(tbl[idx].name, exp_keep.pop_front(), out_tkeep);
               check_last(tbl[idx].name, exp_last.pop_front(), out_tlast);
               // latency only defined with out_tready held high
               if (!tbl[idx].bp) begin
                  check_latency(tbl[idx].name, 1, cycle - exp_cyc.pop_front());
               end else begin
                  void'(exp_cyc.pop_front());
               end
            end
         end
      end
   end

   // --------------------
   // main sequence
   // --------------------

   initial begin
      void'($urandom(72130));
      aclk       = 1'b0;
      rst_n      = 1'b0;
      in_tvalid  = 1'b0;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = 1'b0;
      shift      = '0;
      out_tready = 1'b1;
      bp_on      = 1'b0;
      in_test    = 0;
      in_first   = 1'b1;
      pkt_shift  = '0;
      cycle      = 0;
      err_data   = 0;
      err_keep   = 0;
      err_last   = 0;
      err_other  = 0;
      build_table();
      wd_cycles = 100;
      foreach (tbl[i]) begin
         wd_cycles += tbl[i].len * 4;
      end
      repeat (2) @(posedge aclk);
      rst_n <= 1'b1;
      // idle output until the first beat goes in
      repeat (3) begin
         @(posedge aclk);
         check_valid("reset_state", 1'b0, out_tvalid);
      end
      for (int t = 0; t < tbl.size(); t++) begin
         // switch sink mode only on an empty pipeline
         if (tbl[t].bp != bp_on) begin
            wait_drain();
            bp_on <= tbl[t].bp;
            repeat (2) @(posedge aclk);
         end
         send_packet(t);
      end
      wait_drain();
      // catch stray extra beats
      repeat (5) @(posedge aclk);
      report_counts();
      if (err_data + err_keep + err_last + err_other == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // hang guard, scaled to the table length
   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge aclk);
      $display("ERROR: watchdog expired after %0d cycles with %0d beats outstanding",
               wd_cycles, exp_data.size());
      err_other++;
      report_counts();
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: test/axi4s_rotator_asserts.sv
/*
 * protocol assertions for the axi4s rotator top level
 * reset quiet output and valid/payload stability under back-pressure
 */

`timescale 1ns/1ps

module axi4s_rotator_asserts (
   input logic               aclk,
   input logic               rst_n,
   input logic               in_tvalid,
   input logic               in_tready,
   input axi4s_pkg::tdata_t  in_tdata,
   input axi4s_pkg::tkeep_t  in_tkeep,
   input logic               in_tlast,
   input logic               out_tvalid,
   input logic               out_tready,
   input axi4s_pkg::tdata_t  out_tdata,
   input axi4s_pkg::tkeep_t  out_tkeep,
   input logic               out_tlast
);

   // output register cleared by a reset cycle
   a_reset_idle: assert property (@(posedge aclk) !rst_n |=> !out_tvalid)
      else $error("out_tvalid high after a reset cycle");

   // --------------------
   // stall stability
   // --------------------

   a_out_stable: assert property (@(posedge aclk) disable iff (!rst_n)
      out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
                                    $stable(out_tkeep) && $stable(out_tlast))
      else $error("output beat changed while stalled");

   a_in_stable: assert property (@(posedge aclk) disable iff (!rst_n)
      in_tvalid && !in_tready |=> in_tvalid && $stable(in_tdata) &&
                                  $stable(in_tkeep) && $stable(in_tlast))
      else $error("input beat changed while stalled");

endmodule

bind axi4s_rotator_top axi4s_rotator_asserts u_asserts (
   .aclk       (aclk),
   .rst_n      (rst_n),
   .in_tvalid  (in_tvalid),
   .in_tready  (in_tready),
   .in_tdata   (in_tdata),
   .in_tkeep   (in_tkeep),
   .in_tlast   (in_tlast),
   .out_tvalid (out_tvalid),
   .out_tready (out_tready),
   .out_tdata  (out_tdata),
   .out_tkeep  (out_tkeep),
   .out_tlast  (out_tlast)
);

// File: design/axi4s_rotator_top.sv
/*
 * axi4s packet byte rotator, top level
 * dispatcher, four rotator lanes and collector on plain stream ports
 */

`timescale 1ns/1ps

module axi4s_rotator_top (
   input  logic               aclk,
   input  logic               rst_n,
   // ingress stream
   input  logic               in_tvalid,
   output logic               in_tready,
   input  axi4s_pkg::tdata_t  in_tdata,
   input  axi4s_pkg::tkeep_t  in_tkeep,
   input  logic               in_tlast,
   // rotation, sampled on the first beat of each packet
   input  axi4s_pkg::shift_t  shift,
   // egress stream
   output logic               out_tvalid,
   input  logic               out_tready,
   output axi4s_pkg::tdata_t  out_tdata,
   output axi4s_pkg::tkeep_t  out_tkeep,
   output logic               out_tlast
);

   // --------------------
   // lane links
   // --------------------

   // dispatcher to lanes
   axi4s_intf lane_in [axi4s_pkg::NUM_LANES] (
      .aclk  (aclk),
      .rst_n (rst_n)
   );

   // lanes to collector
   axi4s_intf lane_out [axi4s_pkg::NUM_LANES] (
      .aclk  (aclk),
      .rst_n (rst_n)
   );

   // per-lane packet shift
   axi4s_pkg::shift_t lane_shift [axi4s_pkg::NUM_LANES];

   axi4s_dispatch u_dispatch (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .in_tvalid  (in_tvalid),
      .in_tready  (in_tready),
      .in_tdata   (in_tdata),
      .in_tkeep   (in_tkeep),
      .in_tlast   (in_tlast),
      .shift      (shift),
      .lane_in    (lane_in),
      .lane_shift (lane_shift)
   );

   // --------------------
   // rotator lanes
   // --------------------

   // little endian lanes only
   for (genvar i = 0; i < axi4s_pkg::NUM_LANES; i++) begin : g_rot
      axi4s_shift #(
         .BIGENDIAN (1'b0)
      ) u_shift (
         .axi4s_in  (lane_in[i]),
         .axi4s_out (lane_out[i]),
         .shift     (lane_shift[i])
      );
   end

   axi4s_collect u_collect (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .lane_out   (lane_out),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast)
   );

endmodule

// File: design/axi4s_collect.sv
/*
 * axi4s packet collector
 * drains the rotator lanes in round-robin packet order so the
 * output stream keeps the order of the input packets
 */

`timescale 1ns/1ps

module axi4s_collect (
   input  logic               aclk,
   input  logic               rst_n,
   // lane side
   axi4s_intf.rx              lane_out [axi4s_pkg::NUM_LANES],
   // egress stream
   output logic               out_tvalid,
   input  logic               out_tready,
   output axi4s_pkg::tdata_t  out_tdata,
   output axi4s_pkg::tkeep_t  out_tkeep,
   output logic               out_tlast
);

   axi4s_pkg::lane_t        rd_ptr;
   axi4s_pkg::coll_state_e  state;
   logic                    xfer;

   // lane outputs gathered for indexing
   logic                    lane_vld  [axi4s_pkg::NUM_LANES];
   axi4s_pkg::tdata_t       lane_data [axi4s_pkg::NUM_LANES];
   axi4s_pkg::tkeep_t       lane_keep [axi4s_pkg::NUM_LANES];
   logic                    lane_last [axi4s_pkg::NUM_LANES];

   // --------------------
   // lane mux
   // --------------------

   for (genvar i = 0; i < axi4s_pkg::NUM_LANES; i++) begin : g_lane
      assign lane_vld[i]  = lane_out[i].tvalid;
      assign lane_data[i] = lane_out[i].tdata;
      assign lane_keep[i] = lane_out[i].tkeep;
      assign lane_last[i] = lane_out[i].tlast;
      // back-pressure only to the lane being drained
      assign lane_out[i].tready = out_tready && (rd_ptr == axi4s_pkg::lane_t'(i));
   end

   assign out_tvalid = lane_vld[rd_ptr];
   assign out_tdata  = lane_data[rd_ptr];
   assign out_tkeep  = lane_keep[rd_ptr];
   assign out_tlast  = lane_last[rd_ptr];

   assign xfer = out_tvalid && out_tready;

   // --------------------
   // packet FSM
   // --------------------

   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         state  <= axi4s_pkg::COLL_IDLE;
         rd_ptr <= '0;
      end else if (xfer) begin
         case (state)
            axi4s_pkg::COLL_IDLE: begin
               if (!out_tlast) begin
                  state <= axi4s_pkg::COLL_PKT;
               end
            end
            default: begin
               if (out_tlast) begin
                  state <= axi4s_pkg::COLL_IDLE;
               end
            end
         endcase
         // packet done, move on in the same order as the dispatcher
         if (out_tlast) begin
            rd_ptr <= (rd_ptr == axi4s_pkg::lane_t'(axi4s_pkg::NUM_LANES-1)) ?
                      '0 : rd_ptr + 1'b1;
         end
      end
   end

endmodule

// File: design/axi4s_dispatch.sv
/*
 * axi4s packet dispatcher
 * steers whole packets round-robin to the rotator lanes and latches
 * the shift amount of each packet on its first beat
 */

`timescale 1ns/1ps

module axi4s_dispatch (
   input  logic               aclk,
   input  logic               rst_n,
   // ingress stream
   input  logic               in_tvalid,
   output logic               in_tready,
   input  axi4s_pkg::tdata_t  in_tdata,
   input  axi4s_pkg::tkeep_t  in_tkeep,
   input  logic               in_tlast,
   input  axi4s_pkg::shift_t  shift,
   // lane side
   axi4s_intf.tx              lane_in [axi4s_pkg::NUM_LANES],
   output axi4s_pkg::shift_t  lane_shift [axi4s_pkg::NUM_LANES]
);

   axi4s_pkg::lane_t        wr_ptr;
   axi4s_pkg::disp_state_e  state;
   axi4s_pkg::shift_t       shift_q [axi4s_pkg::NUM_LANES];
   logic                    lane_rdy [axi4s_pkg::NUM_LANES];
   logic                    xfer;
   logic                    first_beat;

   // ready from the selected lane only
   assign in_tready  = lane_rdy[wr_ptr];
   assign xfer       = in_tvalid && in_tready;
   assign first_beat = (state == axi4s_pkg::DISP_IDLE);

   // --------------------
   // lane steering
   // --------------------

   for (genvar i = 0; i < axi4s_pkg::NUM_LANES; i++) begin : g_lane
      // valid only towards the selected lane
      assign lane_in[i].tvalid = in_tvalid && (wr_ptr == axi4s_pkg::lane_t'(i));
      // payload broadcast, lanes ignore it without valid
      assign lane_in[i].tdata  = in_tdata;
      assign lane_in[i].tkeep  = in_tkeep;
      assign lane_in[i].tlast  = in_tlast;
      assign lane_rdy[i]       = lane_in[i].tready;

      // live shift on the first beat, latched copy after that
      assign lane_shift[i] = (first_beat && wr_ptr == axi4s_pkg::lane_t'(i)) ?
                             shift : shift_q[i];
   end

   // per-lane shift capture
   // lane has drained before round robin comes back to it
   always_ff @(posedge aclk) begin
      if (xfer && first_beat) begin
         shift_q[wr_ptr] <= shift;
      end
   end

   // --------------------
   // packet FSM
   // --------------------

   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         state  <= axi4s_pkg::DISP_IDLE;
         wr_ptr <= '0;
      end else if (xfer) begin
         case (state)
            axi4s_pkg::DISP_IDLE: begin
               // single-beat packets stay idle
               if (!in_tlast) begin
                  state <= axi4s_pkg::DISP_PKT;
               end
            end
            default: begin
               if (in_tlast) begin
                  state <= axi4s_pkg::DISP_IDLE;
               end
            end
         endcase
         // next lane after the last beat
         if (in_tlast) begin
            wr_ptr <= (wr_ptr == axi4s_pkg::lane_t'(axi4s_pkg::NUM_LANES-1)) ?
                      '0 : wr_ptr + 1'b1;
         end
      end
   end

endmodule

// File: design/axi4s_shift.sv
/*
 * axi4s byte rotator lane
 * circular rotate of tdata and tkeep toward higher byte positions,
 * followed by one output register stage with full-throughput handshake
 */

`timescale 1ns/1ps

module axi4s_shift #(
   // byte order of the lanes, 0 is little endian
   parameter logic BIGENDIAN = 1'b0
) (
   axi4s_intf.rx              axi4s_in,
   axi4s_intf.tx              axi4s_out,
   // rotation in byte positions
   input axi4s_pkg::shift_t   shift
);

   localparam int DW = axi4s_pkg::DATA_BYTES * 8;
   localparam int KW = axi4s_pkg::DATA_BYTES;

   // byte reversal for big endian lanes
   function automatic axi4s_pkg::tdata_t swap_data(input axi4s_pkg::tdata_t d);
      axi4s_pkg::tdata_t r;
      for (int b = 0; b < axi4s_pkg::DATA_BYTES; b++) begin
         r[b] = d[axi4s_pkg::DATA_BYTES-1-b];
      end
      return r;
   endfunction

   function automatic axi4s_pkg::tkeep_t swap_keep(input axi4s_pkg::tkeep_t k);
      axi4s_pkg::tkeep_t r;
      for (int b = 0; b < axi4s_pkg::DATA_BYTES; b++) begin
         r[b] = k[axi4s_pkg::DATA_BYTES-1-b];
      end
      return r;
   endfunction

   // --------------------
   // rotate datapath
   // --------------------

   axi4s_pkg::tdata_t  data_le;
   axi4s_pkg::tkeep_t  keep_le;
   logic [2*DW-1:0]    data_dbl;
   logic [2*KW-1:0]    keep_dbl;
   axi4s_pkg::tdata_t  data_rot;
   axi4s_pkg::tkeep_t  keep_rot;

   // into little endian order
   assign data_le = BIGENDIAN ? swap_data(axi4s_in.tdata) : axi4s_in.tdata;
   assign keep_le = BIGENDIAN ? swap_keep(axi4s_in.tkeep) : axi4s_in.tkeep;

   // doubled word shifted up, top half is the rotated result
   assign data_dbl = {data_le, data_le} << {shift, 3'b000};
   assign keep_dbl = {keep_le, keep_le} << shift;

   // back into the lane order of the stream
   assign data_rot = BIGENDIAN ? swap_data(data_dbl[2*DW-1:DW]) : data_dbl[2*DW-1:DW];
   assign keep_rot = BIGENDIAN ? swap_keep(keep_dbl[2*KW-1:KW]) : keep_dbl[2*KW-1:KW];

   // --------------------
   // output register
   // --------------------

   logic               out_vld;
   axi4s_pkg::tdata_t  out_data;
   axi4s_pkg::tkeep_t  out_keep;
   logic               out_last;

   // accept when empty or draining this cycle, no bubble
   assign axi4s_in.tready = !out_vld || axi4s_out.tready;

   always_ff @(posedge axi4s_in.aclk) begin
      if (!axi4s_in.rst_n) begin
         out_vld <= 1'b0;
      end else if (axi4s_in.tready) begin
         out_vld <= axi4s_in.tvalid;
      end
   end

   // payload only loads on an accepted beat
   always_ff @(posedge axi4s_in.aclk) begin
      if (axi4s_in.tvalid && axi4s_in.tready) begin
         out_data <= data_rot;
         out_keep <= keep_rot;
         out_last <= axi4s_in.tlast;
      end
   end

   assign axi4s_out.tvalid = out_vld;
   assign axi4s_out.tdata  = out_data;
   assign axi4s_out.tkeep  = out_keep;
   assign axi4s_out.tlast  = out_last;

endmodule

// File: design/axi4s_intf.sv
/*
 * byte-lane AXI4-stream interface
 * tx side drives valid and payload, rx side drives tready
 */

`timescale 1ns/1ps

interface axi4s_intf (
   input logic aclk,
   input logic rst_n
);

   // handshake
   logic                tvalid;
   logic                tready;

   // payload
   axi4s_pkg::tdata_t   tdata;
   axi4s_pkg::tkeep_t   tkeep;
   logic                tlast;

   // source side
   modport tx (
      input  aclk,
      input  rst_n,
      output tvalid,
      input  tready,
      output tdata,
      output tkeep,
      output tlast
   );

   // sink side
   modport rx (
      input  aclk,
      input  rst_n,
      input  tvalid,
      output tready,
      input  tdata,
      input  tkeep,
      input  tlast
   );

endinterface

// File: design/axi4s_pkg.sv
/*
 * axi4s rotator shared definitions
 * stream widths, lane count, payload types and FSM state encodings
 */

package axi4s_pkg;

   // --------------------
   // stream geometry
   // --------------------

   // byte lanes in tdata
   localparam int DATA_BYTES = 8;
   // shift amount width, rotations 0..7
   localparam int SHIFT_WID  = 3;

   // --------------------
   // lane fan-out
   // --------------------

   // parallel rotator lanes
   localparam int NUM_LANES  = 4;
   // lane index width
   localparam int LANE_WID   = 2;

   // payload types
   typedef logic [DATA_BYTES-1:0][7:0] tdata_t;
   typedef logic [DATA_BYTES-1:0]      tkeep_t;
   typedef logic [SHIFT_WID-1:0]       shift_t;
   typedef logic [LANE_WID-1:0]        lane_t;

   // dispatcher FSM, idle waits for first beat of a packet
   typedef enum logic {
      DISP_IDLE,
      DISP_PKT
   } disp_state_e;

   // collector FSM, same meaning on the output side
   typedef enum logic {
      COLL_IDLE,
      COLL_PKT
   } coll_state_e;

endpackage
